//--- sources.f
+incdir+rtl
rtl/exec_pkg.sv
rtl/alu.sv
rtl/move_unit.sv
rtl/meta_unit.sv
rtl/cfu.sv
rtl/execute.sv
rtl/exec_stage.sv
bench/exec_stage_properties.sv
bench/exec_stage_tb.sv

//--- bench/exec_stage_tb.sv
`timescale 1ns/1ps
`include "exec_config.svh"

module exec_stage_tb
  import exec_pkg::*;
();

  localparam int RESET_CYCLES = 10;
  localparam int RAND_VECS    = 64;

  // One row holds a request and the response it should produce
  typedef struct {
    exec_req_t req;
    exec_rsp_t rsp;
  } vec_t;

  logic        clk;
  logic        rst;
  logic        in_valid;
  exec_req_t   req;
  logic        out_valid;
  exec_rsp_t   rsp;
  vec_t        tbl[$];
  exec_rsp_t   exp_q[$];
  int          cycle_count;
  int          cycle_limit;
  logic [31:0] seed;
  vec_t        rv;

  exec_stage dut_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .req       (req),
    .out_valid (out_valid),
    .rsp       (rsp)
  );

  bind exec_stage exec_stage_properties props_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .rsp       (rsp)
  );

  // 40 ns period
  always #20 clk = ~clk;

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Fills request fields with eip and length varying by row number
  function automatic exec_req_t make_req(input opcode_e opc, input logic [31:0] efl,
                                         input logic [31:0] o0, input logic [31:0] o1,
                                         input int idx);
    exec_req_t r;
    r.opc        = opc;
    r.eflags.raw = efl;
    r.eip        = 32'h1000 + 32'(idx) * 32'h10;
    r.instr_len  = 4'(idx % 15 + 1);
    r.opnd0      = o0;
    r.opnd1      = o1;
    r.opnd2      = 32'hc0de_0000 | 32'(idx);
    return r;
  endfunction

  task automatic add_vec(input opcode_e opc, input logic [31:0] efl,
                         input logic [31:0] o0, input logic [31:0] o1,
                         input logic [31:0] x_efl, input logic [31:0] x_o0,
                         input logic [31:0] x_o1, input logic taken);
    vec_t v;
    v.req            = make_req(opc, efl, o0, o1, tbl.size());
    v.rsp.eflags.raw = x_efl;
    // Taken jumps go to opnd0 and the rest fall through
    v.rsp.next_eip   = taken ? o0 : v.req.eip + 32'(v.req.instr_len);
    v.rsp.opnd0_w    = x_o0;
    v.rsp.opnd1_w    = x_o1;
    v.rsp.opnd2_w    = '0;
    tbl.push_back(v);
  endtask

  // Reference for ADD and XOR from the flag rules
  function automatic exec_rsp_t model_add_xor(input exec_req_t r);
    exec_rsp_t   x;
    logic [32:0] wide;
    logic [4:0]  nib;
    logic [31:0] res;
    logic [31:0] efl;
    efl = r.eflags.raw;
    if (r.opc == ADD) begin
      wide = {1'b0, r.opnd0} + {1'b0, r.opnd1};
      nib  = {1'b0, r.opnd0[3:0]} + {1'b0, r.opnd1[3:0]};
      res  = wide[31:0];
      efl[`EFL_CF] = wide[32];
      efl[`EFL_AF] = nib[4];
      // Same input signs, different result sign
      efl[`EFL_OF] = (r.opnd0[31] == r.opnd1[31]) && (res[31] != r.opnd0[31]);
    end else begin
      res = r.opnd0 ^ r.opnd1;
      efl[`EFL_CF] = 1'b0;
      efl[`EFL_OF] = 1'b0;
    end
    efl[`EFL_ZF] = (res == 32'h0);
    efl[`EFL_SF] = res[31];
    efl[`EFL_PF] = ~^res[7:0];
    x.eflags.raw = efl;
    x.next_eip   = r.eip + 32'(r.instr_len);
    x.opnd0_w    = res;
    x.opnd1_w    = r.opnd1;
    x.opnd2_w    = '0;
    return x;
  endfunction

  task automatic build_table();
    // Arithmetic, carry and overflow corners
    add_vec(ADD, 32'h202, 32'h1, 32'h2, 32'h206, 32'h3, 32'h2, 1'b0);
    add_vec(ADD, 32'h202, 32'hffff_ffff, 32'h1, 32'h257, 32'h0, 32'h1, 1'b0);
    add_vec(ADD, 32'h202, 32'h7fff_ffff, 32'h1, 32'ha96, 32'h8000_0000, 32'h1, 1'b0);
    add_vec(ADC, 32'h203, 32'h5, 32'h6, 32'h206, 32'hc, 32'h6, 1'b0);
    add_vec(SUB, 32'h202, 32'h5, 32'h3, 32'h202, 32'h2, 32'h3, 1'b0);
    add_vec(SUB, 32'h202, 32'h0, 32'h1, 32'h297, 32'hffff_ffff, 32'h1, 1'b0);
    add_vec(SUB, 32'h202, 32'h8000_0000, 32'h1, 32'ha16, 32'h7fff_ffff, 32'h1, 1'b0);
    add_vec(SBB, 32'h203, 32'ha, 32'h3, 32'h206, 32'h6, 32'h3, 1'b0);
    add_vec(INC, 32'h203, 32'hf, 32'h55, 32'h213, 32'h10, 32'h55, 1'b0);
    add_vec(DEC, 32'h203, 32'h1, 32'h55, 32'h247, 32'h0, 32'h55, 1'b0);
    add_vec(INC, 32'h202, 32'h7fff_ffff, 32'h0, 32'ha96, 32'h8000_0000, 32'h0, 1'b0);
    add_vec(CMP, 32'h202, 32'h5, 32'h5, 32'h246, 32'h5, 32'h5, 1'b0);
    add_vec(CMP, 32'h202, 32'h3, 32'h5, 32'h293, 32'h3, 32'h5, 1'b0);
    // Reserved and TF/IF bits pass through
    add_vec(ADD, 32'h0024_0302, 32'h1, 32'h1, 32'h0024_0302, 32'h2, 32'h1, 1'b0);
    // Logic ops with CF and OF set on entry
    add_vec(AND, 32'ha03, 32'hf0f0, 32'h0ff0, 32'h206, 32'h00f0, 32'h0ff0, 1'b0);
    add_vec(TEST, 32'ha03, 32'hff00, 32'h00ff, 32'h246, 32'hff00, 32'h00ff, 1'b0);
    add_vec(OR, 32'ha03, 32'h8000_0000, 32'h1, 32'h282, 32'h8000_0001, 32'h1, 1'b0);
    add_vec(XOR, 32'ha03, 32'haa, 32'haa, 32'h246, 32'h0, 32'haa, 1'b0);
    add_vec(NOT, 32'ha03, 32'h0f0f_0f0f, 32'h1234, 32'ha03, 32'hf0f0_f0f0, 32'h1234, 1'b0);
    // Shifts and rotates
    add_vec(SHL, 32'h202, 32'h8000_0001, 32'h1, 32'h203, 32'h2, 32'h1, 1'b0);
    add_vec(SHR, 32'h202, 32'h3, 32'h1, 32'h203, 32'h1, 32'h1, 1'b0);
    add_vec(ROL, 32'h2c3, 32'h8000_0001, 32'h4, 32'h2c2, 32'h18, 32'h4, 1'b0);
    add_vec(ROR, 32'h202, 32'h1, 32'h1, 32'h203, 32'h8000_0000, 32'h1, 1'b0);
    add_vec(SHL, 32'h2c3, 32'h1234, 32'h20, 32'h2c3, 32'h1234, 32'h20, 1'b0);
    // Moves keep EFLAGS
    add_vec(MOV, 32'h8d7, 32'h1111_1111, 32'hdead_beef, 32'h8d7, 32'hdead_beef,
            32'hdead_beef, 1'b0);
    add_vec(LEA, 32'h8d7, 32'h0, 32'h0040_1000, 32'h8d7, 32'h0040_1000, 32'h0040_1000, 1'b0);
    add_vec(MOVSX, 32'h8d7, 32'h0, 32'h80, 32'h8d7, 32'hffff_ff80, 32'h80, 1'b0);
    add_vec(MOVZX, 32'h8d7, 32'h0, 32'h1234_56f0, 32'h8d7, 32'hf0, 32'h1234_56f0, 1'b0);
    add_vec(XCHG, 32'h8d7, 32'haaaa, 32'h5555, 32'h8d7, 32'h5555, 32'haaaa, 1'b0);
    // Flag instructions and AH transfers
    add_vec(STC, 32'h202, 32'h0, 32'h0, 32'h203, 32'h0, 32'h0, 1'b0);
    add_vec(CLC, 32'h8d7, 32'h0, 32'h0, 32'h8d6, 32'h0, 32'h0, 1'b0);
    add_vec(STD, 32'h202, 32'h0, 32'h0, 32'h602, 32'h0, 32'h0, 1'b0);
    add_vec(CLD, 32'h603, 32'h0, 32'h0, 32'h203, 32'h0, 32'h0, 1'b0);
    add_vec(LAHF, 32'h8d7, 32'h1234_5678, 32'h0, 32'h8d7, 32'h1234_d778, 32'h0, 1'b0);
    add_vec(SAHF, 32'h8d6, 32'h4100, 32'h0, 32'h843, 32'h4100, 32'h0, 1'b0);
    // Control flow on ZF
    add_vec(JMP, 32'h202, 32'h2000, 32'h0, 32'h202, 32'h2000, 32'h0, 1'b1);
    add_vec(JZ, 32'h242, 32'h3000, 32'h0, 32'h242, 32'h3000, 32'h0, 1'b1);
    add_vec(JZ, 32'h202, 32'h3000, 32'h0, 32'h202, 32'h3000, 32'h0, 1'b0);
    add_vec(JNZ, 32'h202, 32'h4000, 32'h0, 32'h202, 32'h4000, 32'h0, 1'b1);
    add_vec(JNZ, 32'h242, 32'h4000, 32'h0, 32'h242, 32'h4000, 32'h0, 1'b0);
    add_vec(NOP, 32'h8d7, 32'h77, 32'h88, 32'h8d7, 32'h77, 32'h88, 1'b0);
  endtask

  // Limit from test length plus slack
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: no finish within %0d cycles", cycle_limit);
      abort_run();
    end
  end

  // Responses compared at the falling edge
  always @(negedge clk) begin
    if (dut_i.props_i.fail_count != 0) begin
      $display("A bound assertion on the DUT failed");
      abort_run();
    end else if (!rst && out_valid) begin
      if (exp_q.size() == 0) begin
        $display("Response arrived with no request pending");
        abort_run();
      end else begin
        check_value("rsp.eflags", rsp.eflags.raw, exp_q[0].eflags.raw);
        check_value("rsp.next_eip", rsp.next_eip, exp_q[0].next_eip);
        check_value("rsp.opnd0_w", rsp.opnd0_w, exp_q[0].opnd0_w);
        check_value("rsp.opnd1_w", rsp.opnd1_w, exp_q[0].opnd1_w);
        check_value("rsp.opnd2_w", rsp.opnd2_w, exp_q[0].opnd2_w);
        void'(exp_q.pop_front());
      end
    end
  end

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    in_valid    = 1'b0;
    req         = '0;
    cycle_count = 0;
    seed        = 32'hdd7;
    build_table();
    cycle_limit = RESET_CYCLES + tbl.size() + RAND_VECS + 20;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    // Directed rows at one per cycle
    foreach (tbl[i]) begin
      @(posedge clk);
      in_valid <= 1'b1;
      req      <= tbl[i].req;
      exp_q.push_back(tbl[i].rsp);
    end
    // Random ADD and XOR with a fully random eflags word
    for (int k = 0; k < RAND_VECS; k++) begin
      seed   = lcg_next(seed);
      rv.req = make_req(seed[16] ? ADD : XOR, 32'h0, 32'h0, 32'h0, tbl.size() + k);
      seed   = lcg_next(seed);
      rv.req.opnd0 = seed;
      seed   = lcg_next(seed);
      rv.req.opnd1 = seed;
      seed   = lcg_next(seed);
      rv.req.eflags.raw = seed;
      rv.rsp = model_add_xor(rv.req);
      @(posedge clk);
      in_valid <= 1'b1;
      req      <= rv.req;
      exp_q.push_back(rv.rsp);
    end
    @(posedge clk);
    in_valid <= 1'b0;
    req      <= '0;
    // Drain the pipeline
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    @(posedge clk);
    @(negedge clk);
    if (dut_i.props_i.fail_count == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("A bound assertion on the DUT failed");
      abort_run();
    end
  end

endmodule

//--- bench/exec_stage_properties.sv
`timescale 1ns/1ps

module exec_stage_properties
  import exec_pkg::*;
(
  input logic      clk,
  input logic      rst,
  input logic      in_valid,
  input logic      out_valid,
  input exec_rsp_t rsp
);

  // Number of assertion failures so far
  int fail_count = 0;

  // Output register cleared by reset
  valid_low_after_reset: assert property (@(posedge clk) rst |=> !out_valid)
    else begin
      fail_count++;
      $error("out_valid high in the cycle after reset");
    end

  // Two register stages between in_valid and out_valid
  valid_two_cycle_latency: assert property (@(posedge clk) disable iff (rst)
      (!$past(rst) && !$past(rst, 2)) |-> (out_valid == $past(in_valid, 2)))
    else begin
      fail_count++;
      $error("out_valid does not follow in_valid two cycles later");
    end

  // Third destination never written
  opnd2_always_zero: assert property (@(posedge clk) disable iff (rst)
      out_valid |-> (rsp.opnd2_w == '0))
    else begin
      fail_count++;
      $error("rsp.opnd2_w nonzero on a valid response");
    end

endmodule

//--- rtl/exec_stage.sv
`timescale 1ns/1ps

module exec_stage
  import exec_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      in_valid,
  input  exec_req_t req,
  output logic      out_valid,
  output exec_rsp_t rsp
);

  logic      valid_q;
  exec_req_t req_q;
  exec_rsp_t rsp_d;

  // Input stage request register
  always_ff @(posedge clk) begin
    req_q <= req;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid;
    end
  end

  // Purely combinational execution step
  execute execute_i (
    .req (req_q),
    .rsp (rsp_d)
  );

  // Output stage with no back-pressure
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      rsp       <= '0;
    end else begin
      out_valid <= valid_q;
      rsp       <= rsp_d;
    end
  end

endmodule

//--- rtl/execute.sv
`timescale 1ns/1ps
`include "exec_config.svh"

module execute
  import exec_pkg::*;
(
  input  exec_req_t req,
  output exec_rsp_t rsp
);

  localparam int XLEN = `EXEC_XLEN;

  alu_cntl_t       cntl;
  status_t         status_in;
  status_t         alu_status;
  status_t         meta_status;
  status_t         st_new;
  logic [XLEN-1:0] alu_b;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] mu_a_w;
  logic [XLEN-1:0] mu_b_w;
  logic [XLEN-1:0] meta_result;
  logic [XLEN-1:0] next_eip;
  logic            ah_wr;
  logic            is_alu;
  logic            is_move;
  logic            is_meta;
  logic            keep_cf;
  logic            mv_sext;
  logic            mv_zext;
  logic            mv_swap;
  eflags_u         eflags_out;

  // Opcode decode
  always_comb begin
    cntl.op_add    = req.opc inside {ADD, ADC, INC};
    cntl.op_sub    = req.opc inside {SUB, SBB, DEC, CMP};
    cntl.op_and    = req.opc inside {AND, TEST};
    cntl.op_or     = (req.opc == OR);
    cntl.op_xor    = req.opc inside {XOR, NOT};
    cntl.op_shl    = (req.opc == SHL);
    cntl.op_shr    = (req.opc == SHR);
    cntl.op_rol    = (req.opc == ROL);
    cntl.op_ror    = (req.opc == ROR);
    cntl.use_carry = req.opc inside {ADC, SBB};
    cntl.src_inv   = cntl.op_sub;
    cntl.no_wr     = req.opc inside {CMP, TEST};
    cntl.no_flags  = (req.opc == NOT);
    cntl.clear_cf  = req.opc inside {AND, TEST, OR, XOR};
    cntl.clear_of  = cntl.clear_cf;
    // INC and DEC leave the carry alone
    keep_cf        = req.opc inside {INC, DEC};
    is_move        = req.opc inside {MOV, LEA, MOVSX, MOVZX, XCHG};
    mv_sext        = (req.opc == MOVSX);
    mv_zext        = (req.opc == MOVZX);
    mv_swap        = (req.opc == XCHG);
    is_meta        = req.opc inside {STC, STD, CLC, CLD, LAHF, SAHF};
  end

  assign is_alu = cntl.op_add | cntl.op_sub | cntl.op_and | cntl.op_or | cntl.op_xor |
                  cntl.op_shl | cntl.op_shr | cntl.op_rol | cntl.op_ror;

  // Constant 1 for INC and DEC and all ones so XOR acts as NOT
  assign alu_b = keep_cf             ? XLEN'(1) :
                 (req.opc == NOT)    ? '1       :
                                       req.opnd1;

  assign status_in = '{df: req.eflags.f.df, af: req.eflags.f.af, cf: req.eflags.f.cf,
                       pf: req.eflags.f.pf, zf: req.eflags.f.zf, sf: req.eflags.f.sf,
                       of: req.eflags.f.of};

  alu alu_i (
    .cntl       (cntl),
    .status_in  (status_in),
    .a          (req.opnd0),
    .b          (alu_b),
    .status_out (alu_status),
    .result     (alu_result)
  );

  move_unit move_unit_i (
    .sext (mv_sext),
    .zext (mv_zext),
    .swap (mv_swap),
    .a    (req.opnd0),
    .b    (req.opnd1),
    .a_w  (mu_a_w),
    .b_w  (mu_b_w)
  );

  meta_unit meta_unit_i (
    .opc        (req.opc),
    .opnd       (req.opnd0),
    .status_in  (status_in),
    .ah_wr      (ah_wr),
    .result     (meta_result),
    .status_out (meta_status)
  );

  // Runs on every step
  cfu cfu_i (
    .opc       (req.opc),
    .eflags    (req.eflags),
    .eip       (req.eip),
    .instr_len (req.instr_len),
    .target    (req.opnd0),
    .next_eip  (next_eip)
  );

  // Pick the unit whose flags take effect
  always_comb begin
    st_new = status_in;
    if (is_alu) begin
      st_new = alu_status;
      if (keep_cf) begin
        st_new.cf = status_in.cf;
      end
    end else if (is_meta) begin
      st_new = meta_status;
    end
  end

  // Status merged over the input EFLAGS word
  always_comb begin
    eflags_out = req.eflags;
    eflags_out.raw[`EFL_CF] = st_new.cf;
    eflags_out.raw[`EFL_PF] = st_new.pf;
    eflags_out.raw[`EFL_AF] = st_new.af;
    eflags_out.raw[`EFL_ZF] = st_new.zf;
    eflags_out.raw[`EFL_SF] = st_new.sf;
    eflags_out.raw[`EFL_DF] = st_new.df;
    eflags_out.raw[`EFL_OF] = st_new.of;
  end

  // Written operands
  always_comb begin
    rsp.eflags   = eflags_out;
    rsp.next_eip = next_eip;
    if (is_alu && !cntl.no_wr) begin
      rsp.opnd0_w = alu_result;
    end else if (is_move) begin
      rsp.opnd0_w = mu_a_w;
    end else if (ah_wr) begin
      rsp.opnd0_w = meta_result;
    end else begin
      rsp.opnd0_w = req.opnd0;
    end
    rsp.opnd1_w = is_move ? mu_b_w : req.opnd1;
    // No third destination yet
    rsp.opnd2_w = '0;
  end

endmodule

//--- rtl/cfu.sv
`timescale 1ns/1ps
`include "exec_config.svh"

module cfu
  import exec_pkg::*;
(
  input  opcode_e               opc,
  input  eflags_u               eflags,
  input  logic [`EXEC_XLEN-1:0] eip,
  input  logic [3:0]            instr_len,
  input  logic [`EXEC_XLEN-1:0] target,
  output logic [`EXEC_XLEN-1:0] next_eip
);

  localparam int XLEN = `EXEC_XLEN;

  logic            taken;
  logic [XLEN-1:0] seq_eip;

  // Fall-through address
  assign seq_eip = eip + {{(XLEN-4){1'b0}}, instr_len};

  // Branch decision on ZF only
  always_comb begin
    case (opc)
      JMP:     taken = 1'b1;
      JZ:      taken = eflags.f.zf;
      JNZ:     taken = ~eflags.f.zf;
      default: taken = 1'b0;
    endcase
  end

  assign next_eip = taken ? target : seq_eip;

endmodule

//--- rtl/meta_unit.sv
`timescale 1ns/1ps
`include "exec_config.svh"

module meta_unit
  import exec_pkg::*;
(
  input  opcode_e               opc,
  input  logic [`EXEC_XLEN-1:0] opnd,
  input  status_t               status_in,
  output logic                  ah_wr,
  output logic [`EXEC_XLEN-1:0] result,
  output status_t               status_out
);

  logic [7:0] ah_img;

  // AH image: SF ZF 0 AF 0 PF 1 CF
  assign ah_img = {status_in.sf, status_in.zf, 1'b0, status_in.af,
                   1'b0, status_in.pf, 1'b1, status_in.cf};

  always_comb begin
    ah_wr      = 1'b0;
    result     = opnd;
    status_out = status_in;
    case (opc)
      STC: status_out.cf = 1'b1;
      CLC: status_out.cf = 1'b0;
      STD: status_out.df = 1'b1;
      CLD: status_out.df = 1'b0;
      LAHF: begin
        // Only bits 15:8 of EAX change
        result[15:8] = ah_img;
        ah_wr        = 1'b1;
      end
      SAHF: begin
        status_out.sf = opnd[15];
        status_out.zf = opnd[14];
        status_out.af = opnd[12];
        status_out.pf = opnd[10];
        status_out.cf = opnd[8];
      end
      default: ;
    endcase
  end

endmodule

//--- rtl/move_unit.sv
`timescale 1ns/1ps
`include "exec_config.svh"

module move_unit
  import exec_pkg::*;
(
  input  logic                  sext,
  input  logic                  zext,
  input  logic                  swap,
  input  logic [`EXEC_XLEN-1:0] a,
  input  logic [`EXEC_XLEN-1:0] b,
  output logic [`EXEC_XLEN-1:0] a_w,
  output logic [`EXEC_XLEN-1:0] b_w
);

  localparam int XLEN = `EXEC_XLEN;

  logic [XLEN-1:0] b_sx;
  logic [XLEN-1:0] b_zx;

  // Byte source widened to a full word
  assign b_sx = {{(XLEN-8){b[7]}}, b[7:0]};
  assign b_zx = {{(XLEN-8){1'b0}}, b[7:0]};

  // Destination gets the source in every mode
  assign a_w = sext ? b_sx :
               zext ? b_zx :
                      b;

  // Only XCHG writes the source back
  assign b_w = swap ? a : b;

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ps
`include "exec_config.svh"

module alu
  import exec_pkg::*;
(
  input  alu_cntl_t             cntl,
  input  status_t               status_in,
  input  logic [`EXEC_XLEN-1:0] a,
  input  logic [`EXEC_XLEN-1:0] b,
  output status_t               status_out,
  output logic [`EXEC_XLEN-1:0] result
);

  localparam int XLEN  = `EXEC_XLEN;
  localparam int CNT_W = $clog2(XLEN);

  logic [XLEN-1:0]  b_eff;
  logic             cin;
  logic [XLEN:0]    sum;
  logic [4:0]       nib_sum;
  logic [CNT_W-1:0] cnt;
  logic [XLEN:0]    shl_ext;
  logic [XLEN:0]    shr_ext;
  logic [XLEN-1:0]  rol_res;
  logic [XLEN-1:0]  ror_res;
  logic             is_arith;
  logic             is_shrot;

  // Subtract as a + ~b + 1; borrow-in drops the +1
  assign b_eff = cntl.src_inv ? ~b : b;
  assign cin   = cntl.use_carry ? (status_in.cf ^ cntl.src_inv) : cntl.src_inv;

  assign sum     = {1'b0, a} + {1'b0, b_eff} + {{XLEN{1'b0}}, cin};
  // Low nibble alone, for the auxiliary carry
  assign nib_sum = {1'b0, a[3:0]} + {1'b0, b_eff[3:0]} + {4'b0, cin};

  assign cnt     = b[CNT_W-1:0];
  // Extra bit catches the last bit shifted out
  assign shl_ext = {1'b0, a} << cnt;
  assign shr_ext = {a, 1'b0} >> cnt;
  assign rol_res = (a << cnt) | (a >> (XLEN - int'(cnt)));
  assign ror_res = (a >> cnt) | (a << (XLEN - int'(cnt)));

  assign is_arith = cntl.op_add | cntl.op_sub;
  assign is_shrot = cntl.op_shl | cntl.op_shr | cntl.op_rol | cntl.op_ror;

  always_comb begin
    result     = a;
    status_out = status_in;
    if (is_arith) begin
      result = sum[XLEN-1:0];
      // Carry out inverts to borrow on subtract
      status_out.cf = sum[XLEN] ^ cntl.src_inv;
      status_out.af = nib_sum[4] ^ cntl.src_inv;
      status_out.of = (a[XLEN-1] == b_eff[XLEN-1]) && (sum[XLEN-1] != a[XLEN-1]);
    end else if (cntl.op_and) begin
      result = a & b;
    end else if (cntl.op_or) begin
      result = a | b;
    end else if (cntl.op_xor) begin
      result = a ^ b;
    end else if (cntl.op_shl) begin
      result        = shl_ext[XLEN-1:0];
      status_out.cf = shl_ext[XLEN];
    end else if (cntl.op_shr) begin
      result        = shr_ext[XLEN:1];
      status_out.cf = shr_ext[0];
    end else if (cntl.op_rol) begin
      result        = rol_res;
      status_out.cf = rol_res[0];
    end else if (cntl.op_ror) begin
      result        = ror_res;
      status_out.cf = ror_res[XLEN-1];
    end
    // Logic ops force these low
    if (cntl.clear_cf) begin
      status_out.cf = 1'b0;
    end
    if (cntl.clear_of) begin
      status_out.of = 1'b0;
    end
    // Rotates keep ZF, SF and PF
    if (!cntl.op_rol && !cntl.op_ror) begin
      status_out.zf = (result == '0);
      status_out.sf = result[XLEN-1];
      status_out.pf = ~^result[7:0];
    end
    // NOT, or a zero count, leaves every flag alone
    if (cntl.no_flags || (is_shrot && cnt == '0)) begin
      status_out = status_in;
    end
  end

endmodule

//--- rtl/exec_pkg.sv
`include "exec_config.svh"

package exec_pkg;

  // Decoded instruction classes
  typedef enum logic [`EXEC_OPC_W-1:0] {
    NOP,
    ADD, ADC, INC, SUB, SBB, DEC, CMP,
    AND, TEST, OR, XOR, NOT,
    SHL, SHR, ROL, ROR,
    MOV, LEA, MOVSX, MOVZX, XCHG,
    STC, STD, CLC, CLD, LAHF, SAHF,
    JMP, JZ, JNZ
  } opcode_e;

  // Named view of EFLAGS, MSB first
  typedef struct packed {
    logic [`EXEC_XLEN-13:0] rsvd_hi;
    logic                   of;
    logic                   df;
    logic                   intf;
    logic                   tf;
    logic                   sf;
    logic                   zf;
    logic                   rsvd5;
    logic                   af;
    logic                   rsvd3;
    logic                   pf;
    logic                   rsvd1;
    logic                   cf;
  } eflags_fields_t;

  // Same word, raw or by field
  typedef union packed {
    logic [`EXEC_XLEN-1:0] raw;
    eflags_fields_t        f;
  } eflags_u;

  // Arithmetic and direction flags seen by the units
  typedef struct packed {
    logic df;
    logic af;
    logic cf;
    logic pf;
    logic zf;
    logic sf;
    logic of;
  } status_t;

  typedef struct packed {
    // Core operation, one-hot
    logic op_add;
    logic op_sub;
    logic op_and;
    logic op_or;
    logic op_xor;
    logic op_shl;
    logic op_shr;
    logic op_rol;
    logic op_ror;
    // Modifiers
    logic use_carry;
    logic src_inv;
    logic no_wr;
    logic no_flags;
    logic clear_cf;
    logic clear_of;
  } alu_cntl_t;

  typedef struct packed {
    opcode_e               opc;
    eflags_u               eflags;
    logic [`EXEC_XLEN-1:0] eip;
    logic [3:0]            instr_len;
    logic [`EXEC_XLEN-1:0] opnd0;
    logic [`EXEC_XLEN-1:0] opnd1;
    logic [`EXEC_XLEN-1:0] opnd2;
  } exec_req_t;

  typedef struct packed {
    eflags_u               eflags;
    logic [`EXEC_XLEN-1:0] next_eip;
    logic [`EXEC_XLEN-1:0] opnd0_w;
    logic [`EXEC_XLEN-1:0] opnd1_w;
    logic [`EXEC_XLEN-1:0] opnd2_w;
  } exec_rsp_t;

endpackage

//--- rtl/exec_config.svh
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Datapath word width
`define EXEC_XLEN 32

// Opcode field width, room for 128 opcodes
`define EXEC_OPC_W 7

// EFLAGS bit positions, standard x86 layout
`define EFL_CF 0
`define EFL_PF 2
`define EFL_AF 4
`define EFL_ZF 6
`define EFL_SF 7
`define EFL_TF 8
`define EFL_IF 9
`define EFL_DF 10
`define EFL_OF 11

`endif
